// ==== stepdir_axis.f ====
move_pkg.sv
axis_pkg.sv
move_fifo.sv
move_sequencer.sv
step_pulse.sv
stepdir_axis.sv
stepdir_axis_checker.sv
tb_stepdir_axis.sv

// ==== tb_stepdir_axis.sv ====
`timescale 1ns/1ps

module tb_stepdir_axis;
	import move_pkg::*;
	import axis_pkg::*;

	localparam int depth = 16;
	localparam int pulse_cycles = 8;
	localparam int timeout_cycles = 200000;

	logic clk;
	logic reset;
	move_t move_wr_data;
	logic move_wr_en;
	logic full;
	logic empty;
	logic start;
	logic dedge;
	logic step;
	logic dir;
	logic signed [position_bits-1:0] position;
	logic running;

	logic [31:0] lfsr;
	move_t exp_q[$]; // records the model holds in the queue.
	move_t wr_q[$]; // writes not yet driven.
	logic m_running;
	logic m_dir;
	logic m_step;
	int m_pos;
	int m_left;
	int m_gap; // expected clocks between the last step and the next.
	int m_add;
	int m_since;
	int m_hold; // pulse clocks left.
	int sum_travel; // net travel of every record the queue accepted.
	logic prev_step;
	int step_changes;
	int step_rises;

	stepdir_axis #(
		.depth(depth),
		.pulse_cycles(pulse_cycles)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.move_wr_data(move_wr_data),
		.move_wr_en(move_wr_en),
		.full(full),
		.empty(empty),
		.start(start),
		.dedge(dedge),
		.step(step),
		.dir(dir),
		.position(position),
		.running(running)
	);

	always #4 clk = !clk;

	// ==================================================
	// helpers
	// ==================================================

	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1); // galois step.
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	function automatic move_t make_move();
		move_t m;
		int cnt;
		int ivl;
		int inc;
		cnt = 1 + take_bits(4) % 12;
		ivl = 10 + take_bits(6) % 51;
		inc = take_bits(3) % 7 - 3;
		if (inc < 0)
			ivl = ivl - (cnt - 1) * inc; // last spacing stays at 10 or more.
		m.dir = (take_bits(1) != 0);
		m.interval = interval_bits'(ivl);
		m.count = count_bits'(cnt);
		m.add = add_bits'(inc);
		return m;
	endfunction

	function automatic int travel(input move_t m);
		return m.dir ? int'(m.count) : -int'(m.count);
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_value(input string name, input longint expected, input longint actual);
		if (expected != actual) begin
			$display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			report_failure("DUT output differs from the reference model");
		end
	endtask

	// ==================================================
	// one clock of model, compare and drive
	// ==================================================

	task automatic tick();
		int pre_count;
		logic take;
		logic step_now;
		move_t rec;
		@(negedge clk);
		pre_count = exp_q.size(); // level before the last edge.
		take = 1'b0;
		step_now = 1'b0;
		if (m_running) begin
			m_since++;
			if (m_since == m_gap) begin
				step_now = 1'b1;
				m_pos = m_dir ? m_pos + 1 : m_pos - 1;
				m_left--;
				if (m_left > 0) begin
					m_gap = m_gap + m_add;
					m_since = 0;
				end else if (pre_count > 0) begin
					take = 1'b1; // chains at the last step.
				end else begin
					m_running = 1'b0;
				end
			end
		end else if (start && pre_count > 0) begin
			take = 1'b1;
		end
		if (take) begin
			rec = exp_q.pop_front();
			m_running = 1'b1;
			m_dir = rec.dir;
			m_left = int'(rec.count);
			m_gap = int'(rec.interval);
			m_add = int'($signed(rec.add));
			m_since = 0;
		end
		if (move_wr_en && pre_count < depth) begin
			exp_q.push_back(move_wr_data); // writes while full are lost.
			sum_travel += travel(move_wr_data);
		end
		if (step_now && dedge) begin
			m_step = !m_step;
		end else if (step_now) begin
			m_step = 1'b1;
			m_hold = pulse_cycles;
		end else if (m_hold > 0) begin
			m_hold--;
			if (m_hold == 0)
				m_step = 1'b0;
		end else if (!dedge) begin
			m_step = 1'b0; // single-edge line rests low.
		end
		if (step != prev_step)
			step_changes++;
		if (step && !prev_step)
			step_rises++;
		prev_step = step;
		check_value("running", m_running, running);
		check_value("dir", m_dir, dir);
		check_value("position", m_pos, position);
		check_value("step", m_step, step);
		check_value("empty", exp_q.size() == 0, empty);
		check_value("full", exp_q.size() == depth, full);
		if (dut0.chk0.fail_count != 0)
			report_failure("an assertion in the bound checker failed");
		move_wr_en = (wr_q.size() > 0);
		if (wr_q.size() > 0)
			move_wr_data = wr_q.pop_front();
	endtask

	task automatic wait_writes();
		int cycles;
		cycles = 0;
		while (wr_q.size() > 0 || move_wr_en) begin
			tick();
			cycles++;
			if (cycles > timeout_cycles)
				report_failure("timeout while writing moves into the queue");
		end
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (running || m_running || exp_q.size() > 0 || wr_q.size() > 0 || move_wr_en
				|| m_hold > 0) begin
			tick();
			cycles++;
			if (cycles > timeout_cycles)
				report_failure("timeout waiting for the axis to finish its moves");
		end
	endtask

	// ==================================================
	// scenarios
	// ==================================================

	initial begin
		int exp_pos;
		int moves;
		move_t m;
		lfsr = 32'h8bcd;
		clk = 1'b0;
		reset = 1'b1;
		move_wr_data = '0;
		move_wr_en = 1'b0;
		start = 1'b0;
		dedge = 1'b1;
		m_running = 1'b0;
		m_dir = 1'b0;
		m_step = 1'b0;
		m_pos = 0;
		m_left = 0;
		m_gap = 0;
		m_add = 0;
		m_since = 0;
		m_hold = 0;
		sum_travel = 0;
		prev_step = 1'b0;
		step_changes = 0;
		step_rises = 0;
		exp_pos = 0;
		repeat (16) @(negedge clk);
		reset = 1'b0;

		tick(); // reset state.
		check_value("running", 0, running);
		check_value("step", 0, step);
		check_value("dir", 0, dir);
		check_value("position", 0, position);
		check_value("empty", 1, empty);
		check_value("full", 0, full);

		m = make_move(); // one move, dual-edge.
		wr_q.push_back(m);
		start = 1'b1;
		step_changes = 0;
		wait_idle();
		exp_pos += travel(m);
		check_value("step toggles", m.count, step_changes);
		check_value("position", exp_pos, position);

		dedge = 1'b0; // one move, single-edge.
		m = make_move();
		wr_q.push_back(m);
		step_rises = 0;
		wait_idle();
		exp_pos += travel(m);
		check_value("step pulses", m.count, step_rises);
		check_value("position", exp_pos, position);

		start = 1'b0; // chained moves.
		dedge = 1'b1;
		repeat (4) begin
			m = make_move();
			exp_pos += travel(m);
			wr_q.push_back(m);
		end
		wait_writes();
		start = 1'b1;
		wait_idle();
		check_value("position", exp_pos, position);

		start = 1'b0; // one write more than the queue holds.
		for (int i = 0; i <= depth; i++) begin
			m = make_move();
			if (i < depth)
				exp_pos += travel(m);
			wr_q.push_back(m);
		end
		wait_writes();
		check_value("full", 1, full);
		start = 1'b1;
		wait_idle();
		check_value("position", exp_pos, position);

		moves = 0; // random run.
		while (moves < 40) begin
			if (!m_running && m_hold == 0 && take_bits(2) == 0)
				dedge = (take_bits(1) != 0); // mode only changes while idle.
			repeat (1 + take_bits(2)) begin
				wr_q.push_back(make_move());
				moves++;
			end
			start = (take_bits(2) != 0);
			repeat (8 + take_bits(7)) tick();
		end
		start = 1'b1;
		wait_idle();
		check_value("position", sum_travel, position);

		if (dut0.chk0.fail_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			report_failure("the bound checker reported assertion failures");
		end
	end

endmodule

// ==== stepdir_axis_checker.sv ====
`timescale 1ns/1ps

module stepdir_axis_checker #(
	parameter int pulse_cycles = axis_pkg::pulse_cycles_default
) (
	input logic clk,
	input logic reset,
	input logic dedge,
	input logic step,
	input logic running,
	input logic signed [axis_pkg::position_bits-1:0] position,
	input logic empty,
	input logic rd_en
);
	import axis_pkg::*;

	int fail_count = 0; // assertion failures so far.

	// ==================================================
	// reset and position
	// ==================================================

	reset_idle: assert property (@(posedge clk) reset |=> (!running && !step))
	else begin
		fail_count++;
		$error("running or step still high in the cycle after reset");
	end

	// position moves at most one count per clock.
	position_step: assert property (@(posedge clk) disable iff (reset)
		(position == $past(position)) || (position == $past(position) + 1'b1)
			|| (position == $past(position) - 1'b1))
	else begin
		fail_count++;
		$error("position jumped by more than one step");
	end

	// ==================================================
	// step line and queue
	// ==================================================

	pulse_width: assert property (@(posedge clk) disable iff (reset)
		($rose(step) && !dedge) |-> ##[1:pulse_cycles] !step)
	else begin
		fail_count++;
		$error("single-edge step pulse held high too long");
	end

	pop_guard: assert property (@(posedge clk) disable iff (reset) !(rd_en && empty))
	else begin
		fail_count++;
		$error("queue read while empty");
	end

endmodule

bind stepdir_axis stepdir_axis_checker #(
	.pulse_cycles(pulse_cycles)
) chk0 (
	.clk(clk),
	.reset(reset),
	.dedge(dedge),
	.step(step),
	.running(running),
	.position(position),
	.empty(empty),
	.rd_en(fifo_rd_en)
);

// ==== stepdir_axis.sv ====
`timescale 1ns/1ps

module stepdir_axis #(
	parameter int depth = move_pkg::move_depth_default,
	parameter int pulse_cycles = axis_pkg::pulse_cycles_default
) (
	input logic clk,
	input logic reset,
	input move_pkg::move_t move_wr_data,
	input logic move_wr_en,
	output logic full,
	output logic empty,
	input logic start,
	input logic dedge,
	output logic step,
	output logic dir,
	output logic signed [axis_pkg::position_bits-1:0] position,
	output logic running
);
	import move_pkg::*;

	move_t fifo_rd_data; // head of the queue.
	logic fifo_rd_en;
	logic step_evt; // one clock per step.

	move_fifo #(
		.depth(depth)
	) q0 (
		.clk(clk),
		.reset(reset),
		.wr_data(move_wr_data),
		.wr_en(move_wr_en),
		.full(full),
		.rd_data(fifo_rd_data),
		.rd_en(fifo_rd_en),
		.empty(empty)
	);

	move_sequencer seq0 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.rec(fifo_rd_data),
		.rec_valid(!empty),
		.rec_take(fifo_rd_en),
		.step_evt(step_evt),
		.dir(dir),
		.position(position),
		.running(running)
	);

	step_pulse #(
		.pulse_cycles(pulse_cycles)
	) pulse0 (
		.clk(clk),
		.reset(reset),
		.step_evt(step_evt),
		.dedge(dedge),
		.step(step)
	);

endmodule

// ==== step_pulse.sv ====
`timescale 1ns/1ps

module step_pulse #(
	parameter int pulse_cycles = axis_pkg::pulse_cycles_default
) (
	input logic clk,
	input logic reset,
	input logic step_evt,
	input logic dedge,
	output logic step
);

	localparam int cnt_bits = (pulse_cycles > 1) ? $clog2(pulse_cycles) : 1;
	localparam logic [cnt_bits-1:0] hold_start = cnt_bits'(pulse_cycles - 1);

	logic [cnt_bits-1:0] hold; // clocks left after the current one.

	// ==================================================
	// step line
	// ==================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			step <= 1'b0;
			hold <= '0;
		end else if (step_evt) begin
			if (dedge) begin
				step <= !step; // every edge is a step.
			end else begin
				step <= 1'b1;
				hold <= hold_start;
			end
		end else if (hold != '0) begin
			hold <= hold - 1'b1;
		end else if (!dedge) begin
			// pulse width is over.
			step <= 1'b0;
		end
	end

endmodule

// ==== move_sequencer.sv ====
`timescale 1ns/1ps

module move_sequencer (
	input logic clk,
	input logic reset,
	input logic start,
	input move_pkg::move_t rec,
	input logic rec_valid,
	output logic rec_take,
	output logic step_evt,
	output logic dir,
	output logic signed [axis_pkg::position_bits-1:0] position,
	output logic running
);
	import move_pkg::*;
	import axis_pkg::*;

	// ==================================================
	// move state
	// ==================================================

	logic [count_bits-1:0] count_left; // steps still to emit.
	logic [interval_bits-1:0] interval; // spacing of the step in flight.
	logic [add_bits-1:0] add;
	logic [interval_bits-1:0] countdown; // zero marks the step cycle.
	logic [interval_bits-1:0] add_ext;
	logic [interval_bits-1:0] next_interval;
	logic last_step;
	logic load;

	assign add_ext = {{(interval_bits - add_bits){add[add_bits-1]}}, add};
	assign next_interval = interval + add_ext;

	assign step_evt = running && (countdown == '0);
	assign last_step = step_evt && (count_left == count_bits'(1));

	// start only matters while idle; a running axis chains on its own.
	assign load = rec_valid && ((!running && start) || last_step);
	assign rec_take = load; // head is popped at this edge.

	// ==================================================
	// interval and countdown
	// ==================================================

	always_ff @(posedge clk) begin
		if (load) begin
			interval <= rec.interval;
			add <= rec.add;
			countdown <= rec.interval - interval_bits'(1); // first step after I clocks.
		end else if (step_evt) begin
			interval <= next_interval;
			countdown <= next_interval - interval_bits'(1);
		end else if (running) begin
			countdown <= countdown - interval_bits'(1);
		end
	end

	// ==================================================
	// control, direction and position
	// ==================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			count_left <= '0;
			dir <= 1'b0;
			position <= '0;
		end else begin
			if (load) begin
				running <= 1'b1;
				count_left <= rec.count;
				dir <= rec.dir; // direction switches at the load edge.
			end else if (step_evt) begin
				count_left <= count_left - count_bits'(1);
				if (last_step)
					running <= 1'b0; // queue ran dry.
			end

			// uses the direction of the move that owns this step.
			if (step_evt) begin
				if (dir)
					position <= position + position_bits'(1);
				else
					position <= position - position_bits'(1);
			end
		end
	end

endmodule

// ==== move_fifo.sv ====
`timescale 1ns/1ps

module move_fifo #(
	parameter int depth = move_pkg::move_depth_default
) (
	input logic clk,
	input logic reset,
	input move_pkg::move_t wr_data,
	input logic wr_en,
	output logic full,
	output move_pkg::move_t rd_data,
	input logic rd_en,
	output logic empty
);
	import move_pkg::*;

	localparam int addr_bits = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_bits = $clog2(depth + 1);
	localparam logic [addr_bits-1:0] last_addr = addr_bits'(depth - 1);
	localparam logic [cnt_bits-1:0] full_count = cnt_bits'(depth);

	move_t mem [depth];
	logic [addr_bits-1:0] wr_ptr;
	logic [addr_bits-1:0] rd_ptr;
	logic [cnt_bits-1:0] used;
	logic do_wr;
	logic do_rd;

	assign full = (used == full_count);
	assign empty = (used == '0);
	assign do_wr = wr_en && !full; // writes while full are dropped.
	assign do_rd = rd_en && !empty;

	// head record is visible with no read latency.
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	// ==================================================
	// pointers and occupancy
	// ==================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == last_addr) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == last_addr) ? '0 : rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				used <= used + 1'b1;
			else if (do_rd && !do_wr)
				used <= used - 1'b1; // simultaneous push and pop keeps the level.
		end
	end

endmodule

// ==== axis_pkg.sv ====
package axis_pkg;

	// ==================================================
	// axis level widths and defaults
	// ==================================================

	// signed step position, wraps on overflow.
	localparam int position_bits = 32;

	// high time of one step in single-edge mode.
	// driver chips usually want a couple of microseconds here,
	// scale with the clock when needed.
	localparam int pulse_cycles_default = 8;

endpackage

// ==== move_pkg.sv ====
package move_pkg;

	// ==================================================
	// move record field widths
	// ==================================================

	localparam int interval_bits = 22; // step interval in clocks.
	localparam int count_bits = 26; // steps per move.
	localparam int add_bits = 20; // signed, sign-extended to interval_bits.

	// default number of queue entries.
	localparam int move_depth_default = 512;

	// ==================================================
	// queue record layout, 69 bits
	// ==================================================

	// dir sits in the msb, add in the lsbs.
	typedef struct packed {
		logic dir; // high moves position up.
		logic [interval_bits-1:0] interval; // first step spacing.
		logic [count_bits-1:0] count; // at least 1.
		logic [add_bits-1:0] add; // applied after each step.
	} move_t;

endpackage
